/* source/bft_pkg.sv */
package bft_pkg;

    // network packet geometry
    localparam int PACKET_BITS   = 49;
    localparam int PAYLOAD_BITS  = 32;
    localparam int NUM_LEAF_BITS = 5;
    localparam int NUM_PORT_BITS = 4;
    localparam int NUM_ADDR_BITS = 7;

    // port 0 carries configuration and is not counted here
    localparam int NUM_IN_PORTS  = 2;
    localparam int NUM_OUT_PORTS = 4;

    // one data word as seen by the kernel
    typedef logic [PAYLOAD_BITS-1:0] word_t;

    // fields from the top bit down
    typedef struct packed {
        logic                     vld;
        logic [NUM_LEAF_BITS-1:0] leaf;
        logic [NUM_PORT_BITS-1:0] port;
        logic [NUM_ADDR_BITS-1:0] addr;
        word_t                    payload;
    } bft_packet_t;

    // destination of one output port
    typedef struct packed {
        logic [NUM_LEAF_BITS-1:0] leaf;
        logic [NUM_PORT_BITS-1:0] port;
    } dest_cfg_t;

    // index 0 to 3 selects output port 1 to 4
    typedef struct packed {
        logic       en;
        logic [1:0] index;
        dest_cfg_t  dest;
    } cfg_write_t;

    // sizes of the configuration layouts
    localparam int CFG_WRITE_BITS = $bits(cfg_write_t);
    localparam int DEST_CFG_BITS  = $bits(dest_cfg_t);

    // payload bits above the index that hold a dest_cfg_t
    localparam int CFG_DEST_LSB = 2;
    localparam int CFG_DEST_MSB = CFG_DEST_LSB + DEST_CFG_BITS - 1;

endpackage

/* source/port_fifo.sv */
`timescale 1ns/100ps
module port_fifo #(
    parameter int  DEPTH  = 4,
    parameter type elem_t = logic [31:0]
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push,
    input  elem_t push_data,
    input  logic  pop,
    output elem_t pop_data,
    output logic  empty,
    output logic  full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    elem_t               mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        logic [PTR_BITS-1:0] nxt;
        nxt = (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign empty    = (count == '0);
    assign full     = (count == CNT_BITS'(DEPTH));
    // show-ahead read
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
        end
    end

    // the credit loops around every instance must keep these apart
    a_no_push_full: assert property (@(posedge clk) disable iff (reset) !(push && full));
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

/* source/leaf_rx_demux.sv */
`timescale 1ns/100ps
module leaf_rx_demux import bft_pkg::*; #(
    parameter int LEAF_ID = 5
) (
    input  logic        clk,
    input  logic        reset,
    input  bft_packet_t pkt_in,
    output logic [1:0]  word_push,
    output word_t       word_data,
    output cfg_write_t  cfg_write
);

    logic own_leaf;
    logic is_cfg;
    logic is_port_1;
    logic is_port_2;

    // only packets for this leaf are taken, the rest pass by
    assign own_leaf  = pkt_in.vld && (pkt_in.leaf == NUM_LEAF_BITS'(LEAF_ID));
    assign is_cfg    = own_leaf && (pkt_in.port == NUM_PORT_BITS'(0));
    assign is_port_1 = own_leaf && (pkt_in.port == NUM_PORT_BITS'(1));
    assign is_port_2 = own_leaf && (pkt_in.port == NUM_PORT_BITS'(2));

    // fifo and table both capture on the edge that samples the packet
    assign word_push = {is_port_2, is_port_1};
    assign word_data = pkt_in.payload;

    always_comb begin
        cfg_write       = '0;
        cfg_write.en    = is_cfg;
        cfg_write.index = pkt_in.payload[1:0];
        // leaf and port sit directly above the index
        cfg_write.dest  = dest_cfg_t'(pkt_in.payload[CFG_DEST_MSB:CFG_DEST_LSB]);
    end

    // ports 3 and up are dropped without a trace

    // network side must never present an unknown valid once out of reset
    a_vld_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(pkt_in.vld)
    );

    // a config payload carries nothing above the dest field
    a_cfg_clean: assert property (
        @(posedge clk) disable iff (reset)
        is_cfg |-> (pkt_in.payload[PAYLOAD_BITS-1:CFG_DEST_MSB+1] == '0)
    );

endmodule

/* source/user_kernel.sv */
`timescale 1ns/100ps
module user_kernel import bft_pkg::*; #(
    parameter int OUT_FIFO_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [1:0]                  in_empty,
    input  word_t                       in_data_1,
    input  word_t                       in_data_2,
    output logic [1:0]                  in_pop,
    output logic [NUM_OUT_PORTS-1:0]    out_push,
    output word_t [NUM_OUT_PORTS-1:0]   out_data,
    input  logic [NUM_OUT_PORTS-1:0]    out_credit
);

    localparam int CRED_BITS = $clog2(OUT_FIFO_DEPTH + 1);

    logic [CRED_BITS-1:0]     cred [NUM_OUT_PORTS];
    logic [NUM_OUT_PORTS-1:0] cred_ok;
    logic                     fire;

    for (genvar i = 0; i < NUM_OUT_PORTS; i++) begin : g_cred_ok
        assign cred_ok[i] = (cred[i] != '0);
    end

    // a pair goes only when every result has a free slot waiting
    assign fire   = !in_empty[0] && !in_empty[1] && (&cred_ok);
    assign in_pop = {fire, fire};

    // results land in the output fifos one edge after the pop
    always_ff @(posedge clk) begin
        if (fire) begin
            out_data[0] <= in_data_1 + in_data_2;
            out_data[1] <= in_data_1 - in_data_2;
            out_data[2] <= in_data_1 ^ in_data_2;
            out_data[3] <= (in_data_1 > in_data_2) ? in_data_1 : in_data_2;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_push <= '0;
        end else begin
            out_push <= {NUM_OUT_PORTS{fire}};
        end
    end

    // one credit per output fifo slot, spent on pop, back when the arbiter drains
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                cred[i] <= CRED_BITS'(OUT_FIFO_DEPTH);
            end
        end else begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                cred[i] <= cred[i] - CRED_BITS'(fire) + CRED_BITS'(out_credit[i]);
            end
        end
    end

    // arbiter must never hand back more than the fifo holds
    for (genvar i = 0; i < NUM_OUT_PORTS; i++) begin : g_cred_chk
        a_cred_bound: assert property (
            @(posedge clk) disable iff (reset) cred[i] <= CRED_BITS'(OUT_FIFO_DEPTH)
        );
    end

endmodule

/* source/leaf_tx_arbiter.sv */
`timescale 1ns/100ps
module leaf_tx_arbiter import bft_pkg::*; #(
    parameter int OUT_FIFO_DEPTH = 4,
    parameter int DEST_CREDITS   = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [NUM_OUT_PORTS-1:0]    res_push,
    input  word_t [NUM_OUT_PORTS-1:0]   res_data,
    output logic [NUM_OUT_PORTS-1:0]    res_credit,
    input  cfg_write_t                  cfg_write,
    input  logic [NUM_OUT_PORTS-1:0]    credit_in,
    output bft_packet_t                 pkt_out
);

    localparam int NET_BITS = $clog2(DEST_CREDITS + 1);
    localparam int IDX_BITS = $clog2(NUM_OUT_PORTS);

    word_t [NUM_OUT_PORTS-1:0] fifo_data;
    logic [NUM_OUT_PORTS-1:0]  fifo_empty;
    logic [NUM_OUT_PORTS-1:0]  fifo_pop;
    logic [NUM_OUT_PORTS-1:0]  eligible;

    dest_cfg_t                 dest_table [NUM_OUT_PORTS];
    logic [NET_BITS-1:0]       net_cred [NUM_OUT_PORTS];
    logic [NUM_ADDR_BITS-1:0]  seq [NUM_OUT_PORTS];
    logic [IDX_BITS-1:0]       rr_ptr;
    logic [IDX_BITS-1:0]       grant_idx;
    logic                      grant_vld;
    bft_packet_t               pkt_q;

    for (genvar i = 0; i < NUM_OUT_PORTS; i++) begin : g_out
        port_fifo #(
            .DEPTH  (OUT_FIFO_DEPTH),
            .elem_t (word_t)
        ) out_fifo_inst (
            .clk       (clk),
            .reset     (reset),
            .push      (res_push[i]),
            .push_data (res_data[i]),
            .pop       (fifo_pop[i]),
            .pop_data  (fifo_data[i]),
            .empty     (fifo_empty[i]),
            .full      ()
        );

        assign eligible[i] = !fifo_empty[i] && (net_cred[i] != '0);

        // network may return only what was spent
        a_net_cred_bound: assert property (
            @(posedge clk) disable iff (reset) net_cred[i] <= NET_BITS'(DEST_CREDITS)
        );
    end

    // round-robin search starts at the port after the last winner
    always_comb begin
        logic [IDX_BITS-1:0] cand;
        grant_vld = 1'b0;
        grant_idx = rr_ptr;
        for (int k = 0; k < NUM_OUT_PORTS; k++) begin
            cand = rr_ptr + IDX_BITS'(k);
            if (!grant_vld && eligible[cand]) begin
                grant_vld = 1'b1;
                grant_idx = cand;
            end
        end
    end

    assign fifo_pop   = grant_vld ? (NUM_OUT_PORTS'(1) << grant_idx) : '0;
    assign res_credit = fifo_pop;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                dest_table[i] <= '0;
                net_cred[i]   <= NET_BITS'(DEST_CREDITS);
                seq[i]        <= '0;
            end
            rr_ptr <= '0;
        end else begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                net_cred[i] <= net_cred[i] - NET_BITS'(fifo_pop[i]) + NET_BITS'(credit_in[i]);
                if (fifo_pop[i]) begin
                    seq[i] <= seq[i] + 1'b1;
                end
            end
            if (cfg_write.en) begin
                dest_table[cfg_write.index] <= cfg_write.dest;
            end
            if (grant_vld) begin
                rr_ptr <= grant_idx + 1'b1;
            end
        end
    end

    // one registered packet per cycle
    always_ff @(posedge clk) begin
        if (grant_vld) begin
            pkt_q.leaf    <= dest_table[grant_idx].leaf;
            pkt_q.port    <= dest_table[grant_idx].port;
            pkt_q.addr    <= seq[grant_idx];
            pkt_q.payload <= fifo_data[grant_idx];
        end
        if (reset) begin
            pkt_q.vld <= 1'b0;
        end else begin
            pkt_q.vld <= grant_vld;
        end
    end

    assign pkt_out = pkt_q;

endmodule

/* source/leaf_i2o4.sv */
`timescale 1ns/100ps
module leaf_i2o4 import bft_pkg::*; #(
    parameter int LEAF_ID        = 5,
    parameter int IN_FIFO_DEPTH  = 8,
    parameter int OUT_FIFO_DEPTH = 4,
    parameter int DEST_CREDITS   = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  bft_packet_t              din_leaf_bft2interface,
    output bft_packet_t              dout_leaf_interface2bft,
    output logic [NUM_IN_PORTS-1:0]  credit_leaf2bft,
    input  logic [NUM_OUT_PORTS-1:0] credit_bft2leaf
);

    logic [NUM_IN_PORTS-1:0]   word_push;
    word_t                     word_data;
    cfg_write_t                cfg_write;

    logic [NUM_IN_PORTS-1:0]   in_empty;
    logic [NUM_IN_PORTS-1:0]   in_pop;
    word_t [NUM_IN_PORTS-1:0]  in_data;

    logic [NUM_OUT_PORTS-1:0]  res_push;
    word_t [NUM_OUT_PORTS-1:0] res_data;
    logic [NUM_OUT_PORTS-1:0]  res_credit;

    leaf_rx_demux #(
        .LEAF_ID (LEAF_ID)
    ) rx_demux_inst (
        .clk       (clk),
        .reset     (reset),
        .pkt_in    (din_leaf_bft2interface),
        .word_push (word_push),
        .word_data (word_data),
        .cfg_write (cfg_write)
    );

    // input port 1 on index 0
    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_in
        port_fifo #(
            .DEPTH  (IN_FIFO_DEPTH),
            .elem_t (word_t)
        ) in_fifo_inst (
            .clk       (clk),
            .reset     (reset),
            .push      (word_push[i]),
            .push_data (word_data),
            .pop       (in_pop[i]),
            .pop_data  (in_data[i]),
            .empty     (in_empty[i]),
            .full      ()
        );
    end

    // every word the kernel consumes frees one slot upstream
    assign credit_leaf2bft = in_pop;

    user_kernel #(
        .OUT_FIFO_DEPTH (OUT_FIFO_DEPTH)
    ) user_kernel_inst (
        .clk        (clk),
        .reset      (reset),
        .in_empty   (in_empty),
        .in_data_1  (in_data[0]),
        .in_data_2  (in_data[1]),
        .in_pop     (in_pop),
        .out_push   (res_push),
        .out_data   (res_data),
        .out_credit (res_credit)
    );

    leaf_tx_arbiter #(
        .OUT_FIFO_DEPTH (OUT_FIFO_DEPTH),
        .DEST_CREDITS   (DEST_CREDITS)
    ) tx_arbiter_inst (
        .clk        (clk),
        .reset      (reset),
        .res_push   (res_push),
        .res_data   (res_data),
        .res_credit (res_credit),
        .cfg_write  (cfg_write),
        .credit_in  (credit_bft2leaf),
        .pkt_out    (dout_leaf_interface2bft)
    );

endmodule

/* verification/leaf_i2o4_tb.sv */
`timescale 1ns/100ps
module leaf_i2o4_tb import bft_pkg::*; ();

    localparam int    LEAF_ID        = 5;
    localparam int    IN_FIFO_DEPTH  = 8;
    localparam int    OUT_FIFO_DEPTH = 4;
    localparam int    DEST_CREDITS   = 4;
    localparam string STIM_FILE      = "verification/leaf_i2o4_stim.txt";

    // one parsed line of the stim file
    typedef struct packed {
        logic [7:0] op;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] c;
        logic [7:0] d;
        word_t      v;
    } cmd_t;

    // index is the output port minus one
    typedef struct packed {
        logic [1:0]               index;
        dest_cfg_t                dest;
        logic [NUM_ADDR_BITS-1:0] seq;
        word_t                    value;
    } exp_t;

    logic                     clk;
    logic                     reset;
    bft_packet_t              din;
    bft_packet_t              dout;
    logic [NUM_IN_PORTS-1:0]  credit_out;
    logic [NUM_OUT_PORTS-1:0] credit_in;

    cmd_t      cmds[$];
    string     names[$];
    exp_t      exp_q[$];
    dest_cfg_t dest_tab [NUM_OUT_PORTS];
    int        words_sent [NUM_IN_PORTS];
    int        pulses [NUM_IN_PORTS];
    int        errors;
    int        checks;
    int        tests;
    int        cycles;
    int        limit;

    leaf_i2o4 #(
        .LEAF_ID        (LEAF_ID),
        .IN_FIFO_DEPTH  (IN_FIFO_DEPTH),
        .OUT_FIFO_DEPTH (OUT_FIFO_DEPTH),
        .DEST_CREDITS   (DEST_CREDITS)
    ) i_dut (
        .clk                     (clk),
        .reset                   (reset),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .credit_leaf2bft         (credit_out),
        .credit_bft2leaf         (credit_in)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    task automatic compare_values(input string what, input logic [63:0] got,
                                  input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %0t: %s, got %0h expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic load_stim();
        int          fd;
        int          a;
        int          b;
        int          c;
        int          d;
        logic [31:0] v;
        string       line;
        string       tag;
        string       name;
        cmd_t        cmd;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stim file %s", STIM_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                tag = "";
                a = 0;
                b = 0;
                c = 0;
                d = 0;
                v = '0;
                void'($fgets(line, fd));
                if ($sscanf(line, "%s", tag) == 1 && tag[0] != "#") begin
                    case (tag[0])
                        "P": void'($sscanf(line, "%s %d %d %h", tag, a, b, v));
                        "E": void'($sscanf(line, "%s %d %d %d %d %h", tag, a, b, c, d, v));
                        "T": begin
                            name = "unnamed";
                            void'($sscanf(line, "%s %s", tag, name));
                            names.push_back(name);
                        end
                        default: void'($sscanf(line, "%s %d %d %d", tag, a, b, c));
                    endcase
                    cmd = '{op: tag[0], a: 8'(a), b: 8'(b), c: 8'(c), d: 8'(d), v: v};
                    cmds.push_back(cmd);
                    // cycle limit grows by every W count and by 20 for each packet
                    if (tag[0] == "W") begin
                        limit += a;
                    end else if (tag[0] == "C" || tag[0] == "P" || tag[0] == "E") begin
                        limit += 20;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_packet(input logic [4:0] leaf, input logic [3:0] port,
                               input word_t payload);
        bft_packet_t pkt;
        pkt         = '0;
        pkt.vld     = 1'b1;
        pkt.leaf    = leaf;
        pkt.port    = port;
        pkt.payload = payload;
        @(posedge clk);
        din <= pkt;
        @(posedge clk);
        din <= '0;
    endtask

    task automatic return_credits(input int out_port, input int count);
        repeat (count) begin
            @(posedge clk);
            credit_in <= NUM_OUT_PORTS'(1) << (out_port - 1);
            @(posedge clk);
            credit_in <= '0;
        end
    endtask

    // output port is found from the destination it was set to
    task automatic handle_output(input bft_packet_t pkt);
        int port_idx;
        int pos;
        port_idx = -1;
        pos      = -1;
        for (int i = NUM_OUT_PORTS - 1; i >= 0; i--) begin
            if (dest_tab[i] == {pkt.leaf, pkt.port}) begin
                port_idx = i;
            end
        end
        for (int i = exp_q.size() - 1; i >= 0; i--) begin
            if (int'(exp_q[i].index) == port_idx) begin
                pos = i;
            end
        end
        if (port_idx < 0) begin
            errors++;
            $display("packet at %0t went to leaf %0d port %0d, which no output port uses",
                     $time, pkt.leaf, pkt.port);
        end else if (pos < 0) begin
            errors++;
            $display("output port %0d sent a packet at %0t that was not expected",
                     port_idx + 1, $time);
        end else begin
            compare_values($sformatf("output port %0d packet", port_idx + 1),
                           64'({pkt.leaf, pkt.port, pkt.addr, pkt.payload}),
                           64'({exp_q[pos].dest, exp_q[pos].seq, exp_q[pos].value}));
            exp_q.delete(pos);
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                if (credit_out[i]) begin
                    pulses[i]++;
                end
            end
            if (dout.vld) begin
                handle_output(dout);
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycles++;
            if (cycles >= limit) begin
                $display("timeout, the run reached its limit of %0d cycles", limit);
                $display("Simulation failed");
                $finish;
            end
        end
    end

    task automatic finish_test(input int first_error);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // every word taken from an input fifo returns one credit
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            compare_values($sformatf("credit pulses of input port %0d", i + 1),
                           64'(pulses[i]), 64'(words_sent[i]));
        end
        $display("test %0d %s done, %0d errors", tests + 1, names[tests], errors - first_error);
        tests++;
    endtask

    initial begin
        int first_error;
        din       = '0;
        credit_in = '0;
        reset     = 1'b1;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        cycles    = 0;
        limit     = 0;
        first_error = 0;
        for (int i = 0; i < NUM_OUT_PORTS; i++) begin
            dest_tab[i] = '0;
        end
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            words_sent[i] = 0;
            pulses[i]     = 0;
        end
        load_stim();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        foreach (cmds[k]) begin
            case (cmds[k].op)
                "C": begin
                    dest_tab[cmds[k].a[1:0]] = {cmds[k].b[4:0], cmds[k].c[3:0]};
                    // payload holds leaf and port above the 2-bit index
                    send_packet(5'(LEAF_ID), 4'd0,
                                word_t'({cmds[k].b[4:0], cmds[k].c[3:0], cmds[k].a[1:0]}));
                end
                "P": begin
                    send_packet(cmds[k].a[4:0], cmds[k].b[3:0], cmds[k].v);
                    if (int'(cmds[k].a) == LEAF_ID &&
                        (cmds[k].b == 8'd1 || cmds[k].b == 8'd2)) begin
                        words_sent[cmds[k].b - 8'd1]++;
                    end
                end
                "R": return_credits(int'(cmds[k].a), int'(cmds[k].b));
                "W": repeat (int'(cmds[k].a)) @(posedge clk);
                "E": exp_q.push_back('{index: 2'(cmds[k].a - 8'd1),
                                       dest: {cmds[k].b[4:0], cmds[k].c[3:0]},
                                       seq: cmds[k].d[6:0], value: cmds[k].v});
                "T": begin
                    finish_test(first_error);
                    first_error = errors;
                end
                default: begin
                    errors++;
                    $display("the stim file holds an unknown command");
                end
            endcase
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verification/leaf_i2o4_stim.txt */
# C idx leaf port | P leaf port value | R out_port count | W cycles | T test_name
# E out_port leaf port seq value | values in hex, all other fields decimal
W 12
T idle_after_reset
C 0 9 1
C 1 10 2
C 2 11 3
C 3 12 4
T destination_table
E 1 9 1 0 00000123
E 2 10 2 0 000000bd
E 3 11 3 0 000000c3
E 4 12 4 0 000000f0
E 1 9 1 1 0000000e
E 2 10 2 1 fffffffc
E 3 11 3 1 0000000c
E 4 12 4 1 00000009
P 5 1 000000f0
P 5 2 00000033
P 5 1 00000005
P 5 2 00000009
T data_pairs
P 3 1 deadbeef
P 5 3 0000aaaa
P 5 7 0000bbbb
W 10
T foreign_packets
E 1 9 1 2 ffffffff
E 2 10 2 2 00000001
E 3 11 3 2 ffffffff
E 4 12 4 2 80000000
E 1 9 1 3 12346789
E 2 10 2 3 12344567
E 3 11 3 3 12344769
E 4 12 4 3 12345678
P 5 1 80000000
P 5 2 7fffffff
P 5 1 12345678
P 5 2 00001111
P 5 1 ffffffff
P 5 2 00000002
W 30
E 1 9 1 4 00000001
E 2 10 2 4 fffffffd
E 3 11 3 4 fffffffd
E 4 12 4 4 ffffffff
R 1 1
R 2 1
R 3 1
R 4 1
T back_pressure

/* filelist.f */
source/bft_pkg.sv
source/port_fifo.sv
source/leaf_rx_demux.sv
source/user_kernel.sv
source/leaf_tx_arbiter.sv
source/leaf_i2o4.sv
verification/leaf_i2o4_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the leaf testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module leaf_i2o4_tb -f filelist.f \
    -Mdir obj_dir -o leaf_i2o4_tb
./obj_dir/leaf_i2o4_tb > sim.log
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
